// ==== rtl/exu_params.svh ====
// execute-stage ALU width definitions
// data word, word-mode operand and shift amount widths

`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// data path
`define EXU_XLEN    64

// word-mode operand, low half of a data word
`define EXU_WORD_W  32

// shift amount, log2 of EXU_XLEN
`define EXU_SHAMT_W 6

`endif

// ==== rtl/exu_pkg.sv ====
// execute-stage ALU types
// data word, operation code, multiplier signedness and controller state

`include "exu_params.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0] xlen_t;

    // ====================
    // operation code
    // ====================
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLT    = 5'd2,
        ALU_SLTU   = 5'd3,
        ALU_OR     = 5'd4,
        ALU_AND    = 5'd5,
        ALU_XOR    = 5'd6,
        ALU_SLL    = 5'd7,
        ALU_SRL    = 5'd8,
        ALU_SRA    = 5'd9,
        ALU_MUL    = 5'd10,
        ALU_MULH   = 5'd11,
        ALU_MULHSU = 5'd12,
        ALU_MULHU  = 5'd13,
        ALU_DIV    = 5'd14,
        ALU_DIVU   = 5'd15,
        ALU_REM    = 5'd16,
        ALU_REMU   = 5'd17
    } alu_op_e;

    // multiplicand sign in bit 1, multiplier sign in bit 0
    typedef logic [1:0] mul_sign_t;

    localparam mul_sign_t MUL_UU = 2'b00;
    localparam mul_sign_t MUL_SU = 2'b10;
    localparam mul_sign_t MUL_SS = 2'b11;

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_REQ_MUL  = 3'd1,
        ST_REQ_DIV  = 3'd2,
        ST_WAIT_MUL = 3'd3,
        ST_WAIT_DIV = 3'd4
    } alu_state_e;

endpackage

// ==== rtl/exu_shift.sv ====
// barrel shifter
// left shifts reuse the right shifter on the bit-reversed word

`include "exu_params.svh"

module exu_shift
    import exu_pkg::*;
(
    input  xlen_t                   din,
    input  logic [`EXU_SHAMT_W-1:0] shamt,
    input  logic                    left,
    input  logic                    arith,
    output xlen_t                   dout
);

    logic                   fill;
    xlen_t                  right_in;
    xlen_t                  right_out;
    logic [2*`EXU_XLEN-1:0] ext;

    function automatic xlen_t bit_rev(input xlen_t v);
        xlen_t r;
        for (int i = 0; i < `EXU_XLEN; i++) begin
            r[i] = v[`EXU_XLEN-1-i];
        end
        return r;
    endfunction

    // sign fill only for arithmetic right shifts
    assign fill      = arith & ~left & din[`EXU_XLEN-1];
    assign right_in  = left ? bit_rev(din) : din;
    assign ext       = {{`EXU_XLEN{fill}}, right_in} >> shamt;
    assign right_out = ext[`EXU_XLEN-1:0];
    assign dout      = left ? bit_rev(right_out) : right_out;

endmodule

// ==== rtl/exu_alu_datapath.sv ====
// ALU datapath
// word cut, shared adder/subtractor with less and zero flags,
// logic ops, shifter and single-cycle result select

`include "exu_params.svh"

module exu_alu_datapath
    import exu_pkg::*;
(
    input  alu_op_e op,
    input  logic    word_op,
    input  xlen_t   da,
    input  xlen_t   db,
    output xlen_t   op_a,
    output xlen_t   op_b,
    output xlen_t   comb_result,
    output logic    comb_less,
    output logic    comb_zero
);

    logic  sub_add;
    logic  us;
    logic  lr;
    logic  al;
    xlen_t b_in;
    xlen_t sum;
    logic  carry;
    logic  overflow;
    xlen_t shift_out;

    // ====================
    // word cut
    // ====================
    assign op_a = word_op ? {{(`EXU_XLEN-`EXU_WORD_W){1'b0}}, da[`EXU_WORD_W-1:0]} : da;
    assign op_b = word_op ? {{(`EXU_XLEN-`EXU_WORD_W){1'b0}}, db[`EXU_WORD_W-1:0]} : db;

    // control decode
    assign sub_add = op inside {ALU_SUB, ALU_SLT, ALU_SLTU};
    assign us      = (op == ALU_SLTU);
    assign lr      = (op == ALU_SLL);
    assign al      = (op == ALU_SRA);

    // ====================
    // adder and flags
    // ====================
    assign b_in         = op_b ^ {`EXU_XLEN{sub_add}};
    assign {carry, sum} = op_a + b_in + {{(`EXU_XLEN-1){1'b0}}, sub_add};

    assign overflow  = (op_a[`EXU_XLEN-1] == b_in[`EXU_XLEN-1]) &&
                       (op_a[`EXU_XLEN-1] != sum[`EXU_XLEN-1]);
    // unsigned less is the borrow out of a - b
    assign comb_less = us ? (carry ^ sub_add) : (overflow ^ sum[`EXU_XLEN-1]);
    assign comb_zero = (sum == '0);

    exu_shift u_shift (
        .din   (op_a),
        .shamt (op_b[`EXU_SHAMT_W-1:0]),
        .left  (lr),
        .arith (al),
        .dout  (shift_out)
    );

    // ====================
    // result select
    // ====================
    always_comb begin
        unique case (op)
            ALU_ADD, ALU_SUB: begin
                comb_result = sum;
            end
            ALU_SLT, ALU_SLTU: begin
                comb_result = {{(`EXU_XLEN-1){1'b0}}, comb_less};
            end
            ALU_OR:  comb_result = op_a | op_b;
            ALU_AND: comb_result = op_a & op_b;
            ALU_XOR: comb_result = op_a ^ op_b;
            ALU_SLL, ALU_SRL, ALU_SRA: begin
                comb_result = shift_out;
            end
            // mul/div results come from the external units
            default: comb_result = '0;
        endcase
    end

endmodule

// ==== rtl/exu_alu_ctrl.sv ====
// ALU controller
// issues mul/div requests to the external units, waits for the result
// and owns the registered outputs with their stall and flush rules

module exu_alu_ctrl
    import exu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  logic      flush,
    input  alu_op_e   op,
    input  logic      word_op,
    input  xlen_t     op_a,
    input  xlen_t     op_b,
    input  xlen_t     comb_result,
    input  logic      comb_less,
    input  logic      comb_zero,
    output logic      alu_valid,
    output xlen_t     alu_result,
    output logic      less,
    output logic      zero,
    // multiplier
    output logic      mul_valid,
    output logic      mulw,
    output mul_sign_t mul_signed,
    output xlen_t     multiplicand,
    output xlen_t     multiplier,
    input  logic      mul_ready,
    input  logic      mul_out_valid,
    input  xlen_t     result_hi,
    input  xlen_t     result_lo,
    // divider
    output logic      div_valid,
    output logic      divw,
    output logic      div_signed,
    output xlen_t     dividend,
    output xlen_t     divisor,
    input  logic      div_ready,
    input  logic      div_out_valid,
    input  xlen_t     quotient,
    input  xlen_t     remainder
);

    alu_state_e state;
    alu_state_e next_state;
    logic       clear;
    logic       is_mul;
    logic       is_div;
    logic       launch_mul;
    logic       launch_div;
    logic       mul_done;
    logic       div_done;
    logic       sel_hi_rem;
    mul_sign_t  mul_sign_dec;

    // flush only counts when the stage is not stalled
    assign clear      = reset | (flush & ~stall);
    assign is_mul     = op inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
    assign is_div     = op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    assign launch_mul = (state == ST_IDLE) & ~stall & is_mul;
    assign launch_div = (state == ST_IDLE) & ~stall & is_div;
    assign mul_done   = (state == ST_WAIT_MUL) & mul_out_valid;
    assign div_done   = (state == ST_WAIT_DIV) & div_out_valid;

    always_comb begin
        case (op)
            ALU_MULHSU: mul_sign_dec = MUL_SU;
            ALU_MULHU:  mul_sign_dec = MUL_UU;
            default:    mul_sign_dec = MUL_SS;
        endcase
    end

    // ====================
    // state machine
    // ====================
    always_comb begin
        next_state = state;
        unique case (state)
            ST_IDLE: begin
                if (launch_mul) begin
                    next_state = ST_REQ_MUL;
                end else if (launch_div) begin
                    next_state = ST_REQ_DIV;
                end
            end
            ST_REQ_MUL:  if (mul_ready) next_state = ST_WAIT_MUL;
            ST_REQ_DIV:  if (div_ready) next_state = ST_WAIT_DIV;
            ST_WAIT_MUL: if (mul_out_valid) next_state = ST_IDLE;
            ST_WAIT_DIV: if (div_out_valid) next_state = ST_IDLE;
            default:     next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ====================
    // request channels
    // ====================
    always_ff @(posedge clk) begin
        if (clear) begin
            mul_valid    <= 1'b0;
            mulw         <= 1'b0;
            mul_signed   <= MUL_UU;
            multiplicand <= '0;
            multiplier   <= '0;
            div_valid    <= 1'b0;
            divw         <= 1'b0;
            div_signed   <= 1'b0;
            dividend     <= '0;
            divisor      <= '0;
            sel_hi_rem   <= 1'b0;
        end else if (launch_mul) begin
            mul_valid    <= 1'b1;
            mulw         <= word_op;
            mul_signed   <= mul_sign_dec;
            multiplicand <= op_a;
            multiplier   <= op_b;
            sel_hi_rem   <= (op != ALU_MUL);
        end else if (launch_div) begin
            div_valid    <= 1'b1;
            divw         <= word_op;
            div_signed   <= op inside {ALU_DIV, ALU_REM};
            dividend     <= op_a;
            divisor      <= op_b;
            sel_hi_rem   <= op inside {ALU_REM, ALU_REMU};
        end else begin
            // valid drops once the unit has taken the request
            if (mul_valid && mul_ready) begin
                mul_valid <= 1'b0;
            end
            if (div_valid && div_ready) begin
                div_valid <= 1'b0;
            end
        end
    end

    // ====================
    // output registers
    // ====================
    always_ff @(posedge clk) begin
        if (clear) begin
            alu_valid  <= 1'b1;
            alu_result <= '0;
            less       <= 1'b0;
            zero       <= 1'b0;
        end else if (launch_mul || launch_div) begin
            alu_valid <= 1'b0;
        end else if (state == ST_IDLE && !stall) begin
            alu_result <= comb_result;
            less       <= comb_less;
            zero       <= comb_zero;
        end else if (mul_done) begin
            alu_valid  <= 1'b1;
            alu_result <= sel_hi_rem ? result_hi : result_lo;
        end else if (div_done) begin
            alu_valid  <= 1'b1;
            alu_result <= sel_hi_rem ? remainder : quotient;
        end
    end

endmodule

// ==== rtl/exu_alu.sv ====
// execute-stage ALU
// combinational datapath plus the controller that registers results
// and drives the external multiplier and divider

module exu_alu
    import exu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  logic      flush,
    input  alu_op_e   op,
    input  logic      word_op,
    input  xlen_t     da,
    input  xlen_t     db,
    output logic      alu_valid,
    output xlen_t     alu_result,
    output logic      less,
    output logic      zero,
    output logic      mul_valid,
    output logic      mulw,
    output mul_sign_t mul_signed,
    output xlen_t     multiplicand,
    output xlen_t     multiplier,
    input  logic      mul_ready,
    input  logic      mul_out_valid,
    input  xlen_t     result_hi,
    input  xlen_t     result_lo,
    output logic      div_valid,
    output logic      divw,
    output logic      div_signed,
    output xlen_t     dividend,
    output xlen_t     divisor,
    input  logic      div_ready,
    input  logic      div_out_valid,
    input  xlen_t     quotient,
    input  xlen_t     remainder
);

    xlen_t op_a;
    xlen_t op_b;
    xlen_t comb_result;
    logic  comb_less;
    logic  comb_zero;

    exu_alu_datapath u_datapath (
        .op          (op),
        .word_op     (word_op),
        .da          (da),
        .db          (db),
        .op_a        (op_a),
        .op_b        (op_b),
        .comb_result (comb_result),
        .comb_less   (comb_less),
        .comb_zero   (comb_zero)
    );

    exu_alu_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .flush         (flush),
        .op            (op),
        .word_op       (word_op),
        .op_a          (op_a),
        .op_b          (op_b),
        .comb_result   (comb_result),
        .comb_less     (comb_less),
        .comb_zero     (comb_zero),
        .alu_valid     (alu_valid),
        .alu_result    (alu_result),
        .less          (less),
        .zero          (zero),
        .mul_valid     (mul_valid),
        .mulw          (mulw),
        .mul_signed    (mul_signed),
        .multiplicand  (multiplicand),
        .multiplier    (multiplier),
        .mul_ready     (mul_ready),
        .mul_out_valid (mul_out_valid),
        .result_hi     (result_hi),
        .result_lo     (result_lo),
        .div_valid     (div_valid),
        .divw          (divw),
        .div_signed    (div_signed),
        .dividend      (dividend),
        .divisor       (divisor),
        .div_ready     (div_ready),
        .div_out_valid (div_out_valid),
        .quotient      (quotient),
        .remainder     (remainder)
    );

endmodule

// ==== bench/exu_alu_chk.sv ====
// ALU request channel and flush checks
// bound into the ALU top level

module exu_alu_chk
    import exu_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      stall,
    input logic      flush,
    input logic      alu_valid,
    input logic      mul_valid,
    input logic      mul_ready,
    input logic      mulw,
    input mul_sign_t mul_signed,
    input xlen_t     multiplicand,
    input xlen_t     multiplier,
    input logic      div_valid,
    input logic      div_ready,
    input logic      divw,
    input logic      div_signed,
    input xlen_t     dividend,
    input xlen_t     divisor
);

    // number of failed assertions so far
    int failures = 0;

    // ====================
    // request channels
    // ====================
    a_mul_hold: assert property (@(posedge clk) disable iff (reset)
        mul_valid && !mul_ready && !(flush && !stall) |=>
            mul_valid && $stable(mulw) && $stable(mul_signed) &&
            $stable(multiplicand) && $stable(multiplier))
        else begin
            $error("multiplier request changed before it was accepted");
            failures = failures + 1;
        end

    a_div_hold: assert property (@(posedge clk) disable iff (reset)
        div_valid && !div_ready && !(flush && !stall) |=>
            div_valid && $stable(divw) && $stable(div_signed) &&
            $stable(dividend) && $stable(divisor))
        else begin
            $error("divider request changed before it was accepted");
            failures = failures + 1;
        end

    a_one_unit: assert property (@(posedge clk) disable iff (reset)
        !(mul_valid && div_valid))
        else begin
            $error("multiplier and divider requested at the same time");
            failures = failures + 1;
        end

    // flush clears the whole stage
    a_flush: assert property (@(posedge clk) disable iff (reset)
        flush && !stall |=> alu_valid && !mul_valid && !div_valid)
        else begin
            $error("flush did not return the stage to idle");
            failures = failures + 1;
        end

endmodule

// ==== bench/exu_alu_tb.sv ====
// testbench for the execute-stage ALU
// replays vectors from the pattern file and models the external
// multiplier and divider with random handshake latency

module exu_alu_tb
    import exu_pkg::*;
();

    localparam int MAX_VEC = 64;

    logic      clk;
    logic      reset;
    logic      stall;
    logic      flush;
    alu_op_e   op;
    logic      word_op;
    xlen_t     da;
    xlen_t     db;
    logic      alu_valid;
    xlen_t     alu_result;
    logic      less;
    logic      zero;
    logic      mul_valid;
    logic      mulw;
    mul_sign_t mul_signed;
    xlen_t     multiplicand;
    xlen_t     multiplier;
    logic      mul_ready;
    logic      mul_out_valid;
    xlen_t     result_hi;
    xlen_t     result_lo;
    logic      div_valid;
    logic      divw;
    logic      div_signed;
    xlen_t     dividend;
    xlen_t     divisor;
    logic      div_ready;
    logic      div_out_valid;
    xlen_t     quotient;
    xlen_t     remainder;

    logic [7:0]  vec_id     [MAX_VEC];
    logic [4:0]  vec_op     [MAX_VEC];
    logic        vec_word   [MAX_VEC];
    logic        vec_stall  [MAX_VEC];
    logic        vec_flush  [MAX_VEC];
    xlen_t       vec_da     [MAX_VEC];
    xlen_t       vec_db     [MAX_VEC];
    xlen_t       vec_w1     [MAX_VEC];
    xlen_t       vec_w2     [MAX_VEC];
    xlen_t       vec_result [MAX_VEC];
    logic        vec_less   [MAX_VEC];
    logic        vec_zero   [MAX_VEC];

    int          num_vec;
    int          errors;
    int          failed;
    int          limit;
    int          cycles;
    logic [7:0]  cur_id;
    xlen_t       resp_w1;
    xlen_t       resp_w2;
    logic [31:0] rng_state;

    exu_alu u_exu_alu (.*);

    bind exu_alu exu_alu_chk u_chk (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .flush        (flush),
        .alu_valid    (alu_valid),
        .mul_valid    (mul_valid),
        .mul_ready    (mul_ready),
        .mulw         (mulw),
        .mul_signed   (mul_signed),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .div_valid    (div_valid),
        .div_ready    (div_ready),
        .divw         (divw),
        .div_signed   (div_signed),
        .dividend     (dividend),
        .divisor      (divisor)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic xlen_t cut_operand(input logic word, input xlen_t v);
        return word ? {32'h0, v[31:0]} : v;
    endfunction

    function automatic logic is_mul_op(input alu_op_e o);
        return o inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
    endfunction

    function automatic logic is_div_op(input alu_op_e o);
        return o inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    endfunction

    // signedness table: mulhsu 10, mulhu 00, mul and mulh 11
    function automatic mul_sign_t expected_mul_sign(input alu_op_e o);
        if (o == ALU_MULHSU) begin
            return 2'b10;
        end else if (o == ALU_MULHU) begin
            return 2'b00;
        end else begin
            return 2'b11;
        end
    endfunction

    // divu and remu unsigned, div and rem signed
    function automatic logic expected_div_sign(input alu_op_e o);
        return !(o == ALU_DIVU || o == ALU_REMU);
    endfunction

    task automatic compare_word(input string name, input xlen_t got, input xlen_t exp);
        assert (got === exp) else begin
            $display("[ERROR] test %02h %s got %h expected %h", cur_id, name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("[ERROR] test %02h %s got %h expected %h", cur_id, name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic load_patterns(output int count);
        int    fd;
        int    fields;
        string line;
        count = 0;
        fd = $fopen("bench/exu_alu_patterns.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && count < MAX_VEC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        vec_id[count], vec_op[count], vec_word[count],
                        vec_stall[count], vec_flush[count], vec_da[count],
                        vec_db[count], vec_w1[count], vec_w2[count],
                        vec_result[count], vec_less[count], vec_zero[count]);
                    if (fields == 12) begin
                        count = count + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ====================
    // unit model
    // ====================
    task automatic serve_request(input logic for_mul);
        int ready_wait;
        int out_wait;
        rng_state  = xorshift32(rng_state);
        ready_wait = int'(rng_state % 32'd4);
        rng_state  = xorshift32(rng_state);
        out_wait   = 1 + int'(rng_state % 32'd6);
        repeat (ready_wait) begin
            @(posedge clk);
            #1;
        end
        mul_ready = for_mul;
        div_ready = !for_mul;
        // transfer edge
        @(posedge clk);
        #1;
        mul_ready = 1'b0;
        div_ready = 1'b0;
        repeat (out_wait - 1) begin
            @(posedge clk);
            #1;
        end
        if (for_mul) begin
            result_hi     = resp_w1;
            result_lo     = resp_w2;
            mul_out_valid = 1'b1;
        end else begin
            quotient      = resp_w1;
            remainder     = resp_w2;
            div_out_valid = 1'b1;
        end
        @(posedge clk);
        #1;
        mul_out_valid = 1'b0;
        div_out_valid = 1'b0;
    endtask

    initial begin
        rng_state     = 32'd59660;
        mul_ready     = 1'b0;
        mul_out_valid = 1'b0;
        result_hi     = '0;
        result_lo     = '0;
        div_ready     = 1'b0;
        div_out_valid = 1'b0;
        quotient      = '0;
        remainder     = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mul_valid) begin
                serve_request(1'b1);
            end else if (div_valid) begin
                serve_request(1'b0);
            end
        end
    end

    // ====================
    // vector replay
    // ====================
    task automatic check_launch(input int i);
        xlen_t a_cut;
        xlen_t b_cut;
        a_cut = cut_operand(vec_word[i], vec_da[i]);
        b_cut = cut_operand(vec_word[i], vec_db[i]);
        compare_bit("alu_valid", alu_valid, 1'b0);
        if (is_mul_op(op)) begin
            compare_bit("mul_valid", mul_valid, 1'b1);
            compare_bit("mulw", mulw, vec_word[i]);
            compare_word("mul_signed", mul_signed, expected_mul_sign(op));
            compare_word("multiplicand", multiplicand, a_cut);
            compare_word("multiplier", multiplier, b_cut);
        end else begin
            compare_bit("div_valid", div_valid, 1'b1);
            compare_bit("divw", divw, vec_word[i]);
            compare_bit("div_signed", div_signed, expected_div_sign(op));
            compare_word("dividend", dividend, a_cut);
            compare_word("divisor", divisor, b_cut);
        end
    endtask

    task automatic run_vector(input int i);
        int errors_before;
        errors_before = errors;
        cur_id  = vec_id[i];
        op      = alu_op_e'(vec_op[i]);
        word_op = vec_word[i];
        stall   = vec_stall[i];
        flush   = vec_flush[i];
        da      = vec_da[i];
        db      = vec_db[i];
        resp_w1 = vec_w1[i];
        resp_w2 = vec_w2[i];
        @(posedge clk);
        #1;
        if (stall) begin
            compare_bit("mul_valid", mul_valid, 1'b0);
            compare_bit("div_valid", div_valid, 1'b0);
        end else if (!flush && (is_mul_op(op) || is_div_op(op))) begin
            check_launch(i);
            // operands are don't-care while the unit works
            da = ~vec_da[i];
            db = ~vec_db[i];
        end
        while (!alu_valid) begin
            @(posedge clk);
            #1;
        end
        compare_word("alu_result", alu_result, vec_result[i]);
        compare_bit("less", less, vec_less[i]);
        compare_bit("zero", zero, vec_zero[i]);
        if (errors == errors_before) begin
            $display("test %02h %s: ok", cur_id, op.name());
        end else begin
            failed = failed + 1;
            $display("test %02h %s: mismatch", cur_id, op.name());
        end
    endtask

    initial begin
        wait (limit > 0);
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        reset   = 1'b1;
        stall   = 1'b0;
        flush   = 1'b0;
        op      = ALU_ADD;
        word_op = 1'b0;
        da      = '0;
        db      = '0;
        resp_w1 = '0;
        resp_w2 = '0;
        cur_id  = '0;
        errors  = 0;
        failed  = 0;
        limit   = 0;
        load_patterns(num_vec);
        if (num_vec == 0) begin
            $display("no test vectors could be read from the pattern file");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            limit = num_vec * 16 + 50;
            repeat (10) @(posedge clk);
            #1;
            reset = 1'b0;
            // reset values
            compare_bit("alu_valid", alu_valid, 1'b1);
            compare_word("alu_result", alu_result, '0);
            compare_bit("mul_valid", mul_valid, 1'b0);
            compare_bit("div_valid", div_valid, 1'b0);
            $display("reset: %s", (errors == 0) ? "ok" : "mismatch");
            for (int i = 0; i < num_vec; i++) begin
                run_vector(i);
            end
            assert (u_exu_alu.u_chk.failures == 0) else begin
                $display("the request channel checker saw %0d assertion failures",
                         u_exu_alu.u_chk.failures);
                errors = errors + u_exu_alu.u_chk.failures;
            end
            $display("%0d tests run, %0d failed, %0d errors", num_vec, failed, errors);
            if (errors == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== exu_alu.f ====
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_shift.sv
rtl/exu_alu_datapath.sv
rtl/exu_alu_ctrl.sv
rtl/exu_alu.sv
bench/exu_alu_chk.sv
bench/exu_alu_tb.sv

// ==== bench/exu_alu_patterns.txt ====
# id op word_op stall flush da db resp_hi_or_quotient resp_lo_or_remainder
# expected_result expected_less expected_zero (all hex)
01 00 0 0 0 0000000000000005 0000000000000003 0 0 0000000000000008 0 0
02 01 0 0 0 0000000000000003 0000000000000005 0 0 fffffffffffffffe 1 0
03 01 0 0 0 0000000000001234 0000000000001234 0 0 0000000000000000 0 1
04 00 1 0 0 ffffffff00000001 00000001ffffffff 0 0 0000000100000000 0 0
05 01 1 0 0 1234567800000000 0000000000000001 0 0 ffffffffffffffff 1 0
06 00 0 0 0 ffffffffffffffff 0000000000000001 0 0 0000000000000000 0 1
07 04 0 0 0 00000000000000f0 000000000000000f 0 0 00000000000000ff 0 0
08 05 0 0 0 ffffffff00000000 0000ffff0000ffff 0 0 0000ffff00000000 0 0
09 06 1 0 0 aaaaaaaaffff0000 555555550f0f0f0f 0 0 00000000f0f00f0f 0 0
0a 04 1 0 0 0000000100000000 8000000000000000 0 0 0000000000000000 0 1
0b 02 0 0 0 ffffffffffffffff 0000000000000001 0 0 0000000000000001 1 0
0c 03 0 0 0 ffffffffffffffff 0000000000000001 0 0 0000000000000000 0 0
0d 02 0 0 0 8000000000000000 0000000000000001 0 0 0000000000000001 1 0
0e 02 0 0 0 7fffffffffffffff ffffffffffffffff 0 0 0000000000000000 0 0
0f 03 1 0 0 ffffffff00000001 0000000000000002 0 0 0000000000000001 1 0
10 07 0 0 0 0000000000000001 0000000000000043 0 0 0000000000000008 0 0
11 08 0 0 0 8000000000000000 000000000000003f 0 0 0000000000000001 1 0
12 09 0 0 0 8000000000000000 0000000000000004 0 0 f800000000000000 1 0
13 00 0 1 0 0000000000000001 0000000000000001 0 0 f800000000000000 1 0
14 0a 0 0 0 0000000000000003 0000000000000004 0 000000000000000c 000000000000000c 1 0
15 0d 0 0 0 ffffffffffffffff ffffffffffffffff fffffffffffffffe 1 fffffffffffffffe 1 0
16 0a 0 1 0 0000000000000002 0000000000000002 0 4 fffffffffffffffe 1 0
17 0e 0 0 0 0000000000000064 0000000000000007 e 2 000000000000000e 1 0
18 0f 0 0 0 ffffffffffffffff 0000000000000002 7fffffffffffffff 1 7fffffffffffffff 1 0
19 10 0 0 0 fffffffffffffff9 0000000000000002 fffffffffffffffd ffffffffffffffff ffffffffffffffff 1 0
1a 11 1 0 0 0000000500000011 0000000000000005 3 2 0000000000000002 1 0
1b 00 0 0 1 0000000000000005 0000000000000005 0 0 0000000000000000 0 0
1c 00 0 0 0 fffffffffffffffe 0000000000000001 0 0 ffffffffffffffff 1 0
